/* pet_spi_bridge.f */
+incdir+src
src/pet_spi_pkg.sv
src/spi_byte_if.sv
src/spi_target.sv
src/spi_cmd_engine.sv
src/spi_mem_port.sv
src/pet_spi_bridge.sv
tb/tb_clock_gen.sv
tb/spi_master_bfm.sv
tb/pet_spi_bridge_asserts.sv
tb/pet_spi_bridge_tb.sv

/* run.sh */
#!/bin/sh
# Build the SPI bridge testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module pet_spi_bridge_tb \
    -f pet_spi_bridge.f \
    --Mdir obj_dir
./obj_dir/Vpet_spi_bridge_tb

/* tb/pet_spi_bridge_tb.sv */
// Testbench for the SPI-to-memory bridge: writes, bursts, reads, aborted frames
`timescale 1ns/1ps
`default_nettype none
`include "pet_spi_macros.svh"

module pet_spi_bridge_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int WR_LATENCY  = 5;            // 8th rising SCK to wr_strobe_o
    localparam int DRAIN_LIMIT = 1000;

    logic                   clock;
    logic                   rst;
    logic                   spi_cs_n;
    logic                   spi_sck;
    logic                   spi_mosi;
    logic                   spi_miso;
    logic                   wr_strobe;
    logic [`SPI_ADDR_W-1:0] wr_addr;
    logic [7:0]             wr_data;
    logic [63:0]            last_rise_t;

    logic [7:0]               ref_mem [`SPI_MEM_DEPTH];     // Reference memory
    bit                       ref_valid [`SPI_MEM_DEPTH];   // Location written so far
    logic [`SPI_ADDR_W+7:0]   exp_wr_q [$];                 // Pending {addr, data} reports
    integer                   seed;

    tb_clock_gen clkgen0 (.clock_o(clock), .rst_o(rst));

    spi_master_bfm bfm0 (
        .clock_i     (clock),
        .spi_cs_no   (spi_cs_n),
        .spi_sck_o   (spi_sck),
        .spi_sd_o    (spi_mosi),
        .spi_sd_i    (spi_miso),
        .last_rise_o (last_rise_t)
    );

    pet_spi_bridge dut0 (
        .clock_i     (clock),
        .rst_i       (rst),
        .spi_cs_ni   (spi_cs_n),
        .spi_sck_i   (spi_sck),
        .spi_sd_i    (spi_mosi),
        .spi_sd_o    (spi_miso),
        .wr_strobe_o (wr_strobe),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data)
    );

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic value_error(input string msg);
        abort_run($sformatf("FAIL @%0t: %s", $time, msg));
    endtask

    // Address of data byte n in a frame, wraps at the top of memory
    function automatic logic [`SPI_ADDR_W-1:0] wrap_addr(input logic [`SPI_ADDR_W-1:0] base,
                                                          input int n);
        return `SPI_ADDR_W'((int'(base) + n) % `SPI_MEM_DEPTH);
    endfunction

    // Byte that data slot n of a read frame must return
    function automatic logic [7:0] expected_read(input logic [`SPI_ADDR_W-1:0] base,
                                                 input int n);
        return ref_mem[wrap_addr(base, n)];
    endfunction

    // Each write report is matched against the oldest expectation
    always @(negedge clock) begin
        logic [`SPI_ADDR_W+7:0] exp;
        if (!rst && wr_strobe) begin
            assert (exp_wr_q.size() > 0)
                else value_error($sformatf("unexpected write report addr %0d", wr_addr));
            exp = exp_wr_q.pop_front();
            assert ({wr_addr, wr_data} == exp)
                else value_error($sformatf("write report %0d/%h, expected %0d/%h",
                                           wr_addr, wr_data, exp[17:8], exp[7:0]));
            assert (($time - last_rise_t) / CLK_PERIOD == WR_LATENCY)
                else value_error("write report not 5 cycles after last rising SCK");
        end
    end

    task automatic write_frame(input logic [`SPI_ADDR_W-1:0] base, input int n);
        logic [7:0]             rx;
        logic [7:0]             data;
        logic [4:0]             junk;
        logic [`SPI_ADDR_W-1:0] a;
        junk = 5'($random(seed));               // Ignored command bits
        bfm0.frame_begin();
        bfm0.exchange({1'b1, junk, base[9:8]}, rx);
        bfm0.exchange(base[7:0], rx);
        for (int i = 0; i < n; i++) begin
            data = 8'($random(seed));
            a    = wrap_addr(base, i);
            exp_wr_q.push_back({a, data});
            ref_mem[a]   = data;
            ref_valid[a] = 1'b1;
            bfm0.exchange(data, rx);
        end
        bfm0.frame_end();
    endtask

    task automatic read_frame(input logic [`SPI_ADDR_W-1:0] base, input int n);
        logic [7:0] rx;
        logic [4:0] junk;
        junk = 5'($random(seed));
        bfm0.frame_begin();
        bfm0.exchange({1'b0, junk, base[9:8]}, rx);
        assert (rx == `SPI_IDLE_TX) else value_error($sformatf("command byte gave %h", rx));
        bfm0.exchange(base[7:0], rx);
        assert (rx == `SPI_IDLE_TX) else value_error($sformatf("address byte gave %h", rx));
        for (int i = 0; i < n; i++) begin
            bfm0.exchange(8'($random(seed)), rx);
            if (ref_valid[wrap_addr(base, i)]) begin
                assert (rx == expected_read(base, i))
                    else value_error($sformatf("read addr %0d gave %h, expected %h",
                                               wrap_addr(base, i), rx, expected_read(base, i)));
            end
        end
        bfm0.frame_end();
    endtask

    // CS rises after half a data byte, nothing may be stored
    task automatic aborted_write(input logic [`SPI_ADDR_W-1:0] base);
        logic [7:0] rx;
        bfm0.frame_begin();
        bfm0.exchange({1'b1, 5'd0, base[9:8]}, rx);
        bfm0.exchange(base[7:0], rx);
        bfm0.shift_bits(8'hA5, 4, rx);
        bfm0.frame_end();
    endtask

    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while (exp_wr_q.size() != 0) begin
            @(posedge clock);
            cycles++;
            if (cycles > DRAIN_LIMIT) abort_run("Timeout: expected write reports never arrived");
        end
    endtask

    task automatic wait_reset_done();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(posedge clock);
            cycles++;
            if (cycles > 20) abort_run("Timeout: reset was never released");
        end
    endtask

    initial begin
        logic [`SPI_ADDR_W-1:0] base;
        int                     n;
        seed = 52;
        for (int i = 0; i < `SPI_MEM_DEPTH; i++) ref_valid[i] = 1'b0;
        wait_reset_done();
        @(negedge clock);
        assert (wr_strobe === 1'b0 && spi_miso === 1'b0)
            else value_error("outputs not idle after reset");

        write_frame(10'h123, 1);                 // Single byte
        wait_drained();
        write_frame(10'($random(seed)), 16);
        write_frame(10'd1020, 16);               // Wraps 1023 -> 0
        wait_drained();
        read_frame(10'd1020, 16);
        read_frame(10'h123, 1);

        aborted_write(10'h123);
        read_frame(10'h123, 1);                  // Fresh command after abort

        for (int f = 0; f < 40; f++) begin
            base = 10'($random(seed));
            n    = ($random(seed) & 7) + 1;
            if ($random(seed) & 1) begin
                write_frame(base, n);
            end else begin
                read_frame(base, n);
            end
        end
        wait_drained();
        read_frame(10'd0, `SPI_MEM_DEPTH);       // Full read-back, touched locations checked

        if (exp_wr_q.size() == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run("Write reports still missing at end of run");
        end
    end

endmodule

`default_nettype wire

/* tb/pet_spi_bridge_asserts.sv */
// Bound checks on target byte events, engine memory strobes and frame restart
`timescale 1ns/1ps
`default_nettype none

module pet_spi_bridge_asserts (
    input logic                        clock_i,
    input logic                        rst_i,
    input logic                        cs_i,           // CS pin, high when idle
    input logic                        rx_strobe_i,
    input logic                        frame_start_i,
    input pet_spi_pkg::engine_state_e  state_i,
    input logic                        we_i,
    input logic                        re_i
);

    import pet_spi_pkg::*;

    // A byte only completes while the master holds CS low
    rx_in_frame: assert property (@(posedge clock_i) disable iff (rst_i)
        rx_strobe_i |-> !cs_i)
        else $error("rx_strobe fired while CS was high");

    // One memory access per cycle
    we_re_excl: assert property (@(posedge clock_i) disable iff (rst_i)
        !(we_i && re_i))
        else $error("mem_we and mem_re high together");

    // New frame always restarts at the command byte
    restart_cmd: assert property (@(posedge clock_i) disable iff (rst_i)
        frame_start_i |=> state_i == ST_CMD)
        else $error("engine not in ST_CMD after frame_start");

endmodule

bind spi_target pet_spi_bridge_asserts target_chk (
    .clock_i       (clock_i),
    .rst_i         (rst_i),
    .cs_i          (spi_cs_ni),
    .rx_strobe_i   (rx_strobe_q),
    .frame_start_i (1'b0),                 // Engine side checked in the other bind
    .state_i       (pet_spi_pkg::ST_CMD),
    .we_i          (1'b0),
    .re_i          (1'b0)
);

bind spi_cmd_engine pet_spi_bridge_asserts engine_chk (
    .clock_i       (clock_i),
    .rst_i         (rst_i),
    .cs_i          (1'b0),                 // CS not visible here
    .rx_strobe_i   (1'b0),
    .frame_start_i (bus.frame_start),
    .state_i       (state_q),
    .we_i          (mem_we_o),
    .re_i          (mem_re_o)
);

`default_nettype wire

/* tb/spi_master_bfm.sv */
// SPI mode 0 master model: frame start, byte exchange and frame end tasks
`timescale 1ns/1ps
`default_nettype none

module spi_master_bfm (
    input  logic        clock_i,
    output logic        spi_cs_no,
    output logic        spi_sck_o,
    output logic        spi_sd_o,      // Master to target
    input  logic        spi_sd_i,      // Target to master
    output logic [63:0] last_rise_o    // Time of latest rising SCK
);

    localparam int HALF = 10;          // clock_i cycles per SCK phase

    initial begin
        spi_cs_no   = 1'b1;
        spi_sck_o   = 1'b0;            // Mode 0 idles low
        spi_sd_o    = 1'b0;
        last_rise_o = '0;
    end

    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clock_i);
    endtask

    task automatic frame_begin();
        @(posedge clock_i);
        spi_cs_no <= 1'b0;
        idle(HALF);
    endtask

    // Shifts nbits MSB first, data set while SCK low, target sampled on the rise
    task automatic shift_bits(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        rx = 8'h00;
        for (int i = 7; i > 7 - nbits; i--) begin
            spi_sd_o <= tx[i];
            idle(HALF);
            spi_sck_o   <= 1'b1;
            last_rise_o = $time;
            rx = {rx[6:0], spi_sd_i};  // SDO settled long before this edge
            idle(HALF);
            spi_sck_o <= 1'b0;
        end
    endtask

    task automatic exchange(input logic [7:0] tx, output logic [7:0] rx);
        shift_bits(tx, 8, rx);
    endtask

    task automatic frame_end();
        idle(HALF);
        spi_cs_no <= 1'b1;
        idle(2 * HALF);                // Gap between frames
    endtask

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source: 20 ns clock, reset held for two cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clock_o,
    output logic rst_o
);

    initial begin
        clock_o = 1'b0;
        forever #10 clock_o = ~clock_o;     // 20 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clock_o);
        rst_o <= 1'b0;                      // Released on a rising edge
    end

endmodule

`default_nettype wire

/* src/pet_spi_bridge.sv */
// SPI-to-memory bridge top: target, command engine and memory wired to pins
`timescale 1ns/1ps
`default_nettype none
`include "pet_spi_macros.svh"

module pet_spi_bridge (
    input  logic                   clock_i,
    input  logic                   rst_i,
    input  logic                   spi_cs_ni,     // From MCU, active low
    input  logic                   spi_sck_i,
    input  logic                   spi_sd_i,      // MCU to FPGA
    output logic                   spi_sd_o,      // FPGA to MCU
    output logic                   wr_strobe_o,   // One pulse per stored byte
    output logic [`SPI_ADDR_W-1:0] wr_addr_o,
    output logic [7:0]             wr_data_o
);

    logic                   mem_we;
    logic                   mem_re;
    logic [`SPI_ADDR_W-1:0] mem_addr;
    logic [7:0]             mem_wdata;
    logic [7:0]             mem_rdata;

    spi_byte_if byte_bus ();

    spi_target target0 (
        .clock_i   (clock_i),
        .rst_i     (rst_i),
        .spi_cs_ni (spi_cs_ni),
        .spi_sck_i (spi_sck_i),
        .spi_sd_i  (spi_sd_i),
        .spi_sd_o  (spi_sd_o),
        .bus       (byte_bus.target)
    );

    spi_cmd_engine engine0 (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .bus         (byte_bus.engine),
        .mem_we_o    (mem_we),
        .mem_re_o    (mem_re),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    spi_mem_port mem0 (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .we_i        (mem_we),
        .re_i        (mem_re),
        .addr_i      (mem_addr),
        .wdata_i     (mem_wdata),
        .rdata_o     (mem_rdata),
        .wr_strobe_o (wr_strobe_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o)
    );

endmodule

`default_nettype wire

/* src/spi_mem_port.sv */
// 1024x8 byte memory with registered read and an external write report
`timescale 1ns/1ps
`default_nettype none
`include "pet_spi_macros.svh"

module spi_mem_port (
    input  logic                   clock_i,
    input  logic                   rst_i,
    input  logic                   we_i,
    input  logic                   re_i,
    input  logic [`SPI_ADDR_W-1:0] addr_i,
    input  logic [7:0]             wdata_i,
    output logic [7:0]             rdata_o,       // One cycle after re_i
    output logic                   wr_strobe_o,   // One cycle after we_i
    output logic [`SPI_ADDR_W-1:0] wr_addr_o,
    output logic [7:0]             wr_data_o
);

    logic [7:0] mem_q [`SPI_MEM_DEPTH];

    // Storage array, synchronous read
    always_ff @(posedge clock_i) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        if (re_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            wr_strobe_o <= 1'b0;
        end else begin
            wr_strobe_o <= we_i;        // Report every accepted write
        end
    end

    // Address and data held until next write
    always_ff @(posedge clock_i) begin
        if (we_i) begin
            wr_addr_o <= addr_i;
            wr_data_o <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* src/spi_cmd_engine.sv */
// Frame parser: command and address decode, auto-increment memory access
`timescale 1ns/1ps
`default_nettype none
`include "pet_spi_macros.svh"

module spi_cmd_engine (
    input  logic                   clock_i,
    input  logic                   rst_i,
    spi_byte_if.engine             bus,
    output logic                   mem_we_o,      // Write pulse
    output logic                   mem_re_o,      // Read pulse
    output logic [`SPI_ADDR_W-1:0] mem_addr_o,
    output logic [7:0]             mem_wdata_o,
    input  logic [7:0]             mem_rdata_i    // Valid one cycle after mem_re_o
);

    import pet_spi_pkg::*;

    localparam int HI_W = `SPI_ADDR_W - 8;     // Address bits carried in command byte

    engine_state_e          state_q;
    spi_op_e                op_q;               // Op of current frame
    logic [HI_W-1:0]        addr_hi_q;          // Upper address bits from byte 0
    logic [`SPI_ADDR_W-1:0] addr_q;             // Current memory address
    logic                   re_q;               // Read data arrives this cycle
    logic [7:0]             tx_q;               // Byte offered to target

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            state_q   <= ST_CMD;
            op_q      <= OP_READ;
            addr_hi_q <= '0;
            addr_q    <= '0;
            mem_we_o  <= 1'b0;
            mem_re_o  <= 1'b0;
            re_q      <= 1'b0;
            tx_q      <= `SPI_IDLE_TX;
        end else begin
            mem_we_o <= 1'b0;
            mem_re_o <= 1'b0;
            re_q     <= mem_re_o;

            // Step past the location just written or prefetched, wraps naturally
            if (mem_we_o || (mem_re_o && op_q == OP_READ)) begin
                addr_q <= addr_q + 1'b1;
            end

            if (re_q) begin
                tx_q <= mem_rdata_i;                    // Goes out during next byte
            end

            if (bus.frame_start || bus.frame_end) begin
                state_q <= ST_CMD;
                tx_q    <= `SPI_IDLE_TX;                // Idle byte for cmd and addr
            end else if (bus.rx_strobe) begin
                case (state_q)
                    ST_CMD: begin
                        op_q      <= spi_op_e'(bus.rx_data[7]);
                        addr_hi_q <= bus.rx_data[HI_W-1:0];
                        state_q   <= ST_ADDR;
                    end
                    ST_ADDR: begin
                        addr_q   <= {addr_hi_q, bus.rx_data};
                        mem_re_o <= 1'b1;               // Prefetch first location
                        state_q  <= ST_DATA;
                    end
                    ST_DATA: begin
                        if (op_q == OP_WRITE) begin
                            mem_we_o <= 1'b1;
                        end else begin
                            mem_re_o <= 1'b1;           // Fetch byte for next slot
                        end
                    end
                    default: state_q <= ST_CMD;
                endcase
            end
        end
    end

    // Write data follows the strobe that produced it
    always_ff @(posedge clock_i) begin
        if (bus.rx_strobe && state_q == ST_DATA) begin
            mem_wdata_o <= bus.rx_data;
        end
    end

    assign mem_addr_o  = addr_q;
    assign bus.tx_data = tx_q;

endmodule

`default_nettype wire

/* src/spi_target.sv */
// SPI mode 0 target: pin sync, byte shift in and out, frame and byte events
`timescale 1ns/1ps
`default_nettype none
`include "pet_spi_macros.svh"

module spi_target (
    input  logic      clock_i,
    input  logic      rst_i,
    input  logic      spi_cs_ni,    // Chip select, active low
    input  logic      spi_sck_i,    // Serial clock from master
    input  logic      spi_sd_i,     // Serial data from master
    output logic      spi_sd_o,     // Serial data to master
    spi_byte_if.target bus
);

    localparam int SYNC_LAST = `SPI_SYNC_STAGES - 1;

    logic [`SPI_SYNC_STAGES-1:0] cs_sync_q;     // CS synchronizer chain
    logic [`SPI_SYNC_STAGES-1:0] sck_sync_q;    // SCK synchronizer chain
    logic [`SPI_SYNC_STAGES-1:0] sd_sync_q;     // SDI synchronizer chain
    logic                        cs_d_q;        // Previous synced CS
    logic                        sck_d_q;       // Previous synced SCK

    logic cs_s;
    logic sck_s;
    logic sd_s;
    logic sck_rise;
    logic sck_fall;
    logic cs_fall;
    logic cs_rise;

    logic [2:0] bit_cnt_q;      // Bits received in current byte
    logic [7:0] rx_shift_q;     // Receive shift register
    logic [7:0] tx_shift_q;     // Transmit shift register, MSB on pin
    logic       load_pend_q;    // Load tx_data at next falling SCK
    logic       rx_strobe_q;
    logic       frame_start_q;
    logic       frame_end_q;

    // Two-flop synchronizers plus one edge-history flop per pin
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            cs_sync_q  <= '1;               // CS idles high
            sck_sync_q <= '0;               // Mode 0 SCK idles low
            sd_sync_q  <= '0;
            cs_d_q     <= 1'b1;
            sck_d_q    <= 1'b0;
        end else begin
            cs_sync_q  <= {cs_sync_q[SYNC_LAST-1:0], spi_cs_ni};
            sck_sync_q <= {sck_sync_q[SYNC_LAST-1:0], spi_sck_i};
            sd_sync_q  <= {sd_sync_q[SYNC_LAST-1:0], spi_sd_i};
            cs_d_q     <= cs_sync_q[SYNC_LAST];
            sck_d_q    <= sck_sync_q[SYNC_LAST];
        end
    end

    assign cs_s  = cs_sync_q[SYNC_LAST];
    assign sck_s = sck_sync_q[SYNC_LAST];
    assign sd_s  = sd_sync_q[SYNC_LAST];

    // SCK edges only count inside a frame
    assign sck_rise = sck_s & ~sck_d_q & ~cs_s;
    assign sck_fall = ~sck_s & sck_d_q & ~cs_s;
    assign cs_fall  = ~cs_s & cs_d_q;
    assign cs_rise  = cs_s & ~cs_d_q;

    // Bit count, byte strobe and frame pulses
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            bit_cnt_q     <= 3'd0;
            rx_strobe_q   <= 1'b0;
            frame_start_q <= 1'b0;
            frame_end_q   <= 1'b0;
            load_pend_q   <= 1'b0;
        end else begin
            frame_start_q <= cs_fall;
            frame_end_q   <= cs_rise;
            rx_strobe_q   <= 1'b0;
            if (cs_s) begin
                bit_cnt_q   <= 3'd0;        // Partial byte is dropped
                load_pend_q <= 1'b0;
            end else if (sck_rise) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
                if (bit_cnt_q == 3'd7) begin
                    rx_strobe_q <= 1'b1;    // 8th sample just taken
                    load_pend_q <= 1'b1;
                end
            end else if (sck_fall && load_pend_q) begin
                load_pend_q <= 1'b0;        // Next byte now loaded
            end
        end
    end

    // Sample SDI on rising SCK, MSB first
    always_ff @(posedge clock_i) begin
        if (sck_rise) begin
            rx_shift_q <= {rx_shift_q[6:0], sd_s};
        end
    end

    // Shift SDO on falling SCK, reload between bytes
    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            tx_shift_q <= 8'h00;            // SDO low out of reset
        end else if (cs_fall) begin
            tx_shift_q <= `SPI_IDLE_TX;
        end else if (cs_rise) begin
            tx_shift_q <= 8'h00;            // SDO idles low between frames
        end else if (sck_fall) begin
            if (load_pend_q) begin
                tx_shift_q <= bus.tx_data;
            end else begin
                tx_shift_q <= {tx_shift_q[6:0], 1'b0};
            end
        end
    end

    assign spi_sd_o = tx_shift_q[7];

    assign bus.frame_start = frame_start_q;
    assign bus.frame_end   = frame_end_q;
    assign bus.rx_strobe   = rx_strobe_q;
    assign bus.rx_data     = rx_shift_q;    // Full byte when rx_strobe is high

endmodule

`default_nettype wire

/* src/spi_byte_if.sv */
// Byte-level link between the SPI target and the command engine
`timescale 1ns/1ps
`default_nettype none

interface spi_byte_if;

    logic       frame_start;    // CS fell, one-cycle pulse
    logic [7:0] rx_data;        // Received byte, valid with rx_strobe
    logic       rx_strobe;      // Full byte received, one-cycle pulse
    logic       frame_end;      // CS rose, one-cycle pulse
    logic [7:0] tx_data;        // Next byte to shift out

    // Pin side, produces byte events
    modport target (
        output frame_start,
        output rx_data,
        output rx_strobe,
        output frame_end,
        input  tx_data
    );

    // Command side, consumes byte events
    modport engine (
        input  frame_start,
        input  rx_data,
        input  rx_strobe,
        input  frame_end,
        output tx_data
    );

endinterface

`default_nettype wire

/* src/pet_spi_pkg.sv */
// SPI bridge package: command op and engine phase types shared by the design
`default_nettype none

package pet_spi_pkg;

    // Op selected by bit 7 of the command byte
    typedef enum logic {
        OP_READ  = 1'b0,    // Memory bytes go back on SDO
        OP_WRITE = 1'b1     // Data bytes are stored
    } spi_op_e;

    // Engine phase within one CS-low frame
    typedef enum logic [1:0] {
        ST_CMD  = 2'd0,     // Waiting for command byte
        ST_ADDR = 2'd1,     // Waiting for low address byte
        ST_DATA = 2'd2      // Streaming data bytes
    } engine_state_e;

endpackage

`default_nettype wire

/* src/pet_spi_macros.svh */
// SPI bridge sizing macros: address width, memory depth, sync depth, idle tx byte
`ifndef PET_SPI_MACROS_SVH
`define PET_SPI_MACROS_SVH

// Memory address width in bits
`define SPI_ADDR_W 10

// Number of byte locations
`define SPI_MEM_DEPTH 1024

// Flops per SPI pin synchronizer
`define SPI_SYNC_STAGES 2

// Byte shifted out during command and address bytes
`define SPI_IDLE_TX 8'h00

`endif
